//--- common/uart_pkg.sv
package uart_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    typedef enum logic [2:0] {
        UART_RESET,
        UART_IDLE,
        UART_READ_DATA,
        UART_WRITE_START,
        UART_WRITE_DATA,
        UART_FINISH_READ,
        UART_FINISH_WRITE
    } uart_state_t;

    typedef enum logic [2:0] {
        ECHO_COLLECT,
        ECHO_LAUNCH,
        ECHO_WAIT_BUSY,
        ECHO_WAIT_IDLE,
        ECHO_SEND_CR
    } echo_state_t;

    // Line terminator
    localparam uart_byte_t ASCII_CR = 8'h0D;

    // Lowercase range and the bit that separates the two cases
    localparam uart_byte_t ASCII_LC_A     = 8'h61;
    localparam uart_byte_t ASCII_LC_Z     = 8'h7A;
    localparam uart_byte_t ASCII_CASE_BIT = 8'h20;

    // Line samples per bit period while idle
    localparam int SAMPLES_PER_BIT = 8;

endpackage

//--- uart/uart.sv
`timescale 1ns/1ps

module uart import uart_pkg::*; #(
    parameter int CLK_HZ = 50000000,
    parameter int BAUD   = 9600
) (
    input  logic       clk50MHz,
    input  logic       rst,
    input  logic       rx,
    output logic       tx,
    output logic       busy,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    input  uart_byte_t tx_data,
    input  logic       tx_valid
);

    localparam int CLKS_PER_BIT    = CLK_HZ / BAUD;
    localparam int CLKS_PER_SAMPLE = CLKS_PER_BIT / SAMPLES_PER_BIT;
    localparam int START_SAMPLES   = SAMPLES_PER_BIT / 2;

    // Widest interval is the two bit stop level after a write
    localparam int CYC_W = $clog2(2 * CLKS_PER_BIT);
    localparam int SMP_W = $clog2(CLKS_PER_SAMPLE + 1);

    localparam logic [CYC_W-1:0] BIT_LAST   = CYC_W'(CLKS_PER_BIT - 1);
    localparam logic [CYC_W-1:0] STOP_LAST  = CYC_W'(2 * CLKS_PER_BIT - 1);
    localparam logic [CYC_W-1:0] VALID_CYC  = CYC_W'(1);
    localparam logic [SMP_W-1:0] SAMPLE_LAST = SMP_W'(CLKS_PER_SAMPLE - 1);

    uart_state_t state;
    uart_state_t next_state;

    logic [CYC_W-1:0]         cycle_cnt;
    logic [SMP_W-1:0]         sample_cnt;
    logic [2:0]               bit_cnt;
    logic [START_SAMPLES-1:0] start_samples;
    uart_byte_t               data_shreg;

    logic cycle_en;
    logic cycle_clr;
    logic sample_en;
    logic sample_clr;
    logic sample_shift;
    logic sample_fill;
    logic bit_en;
    logic bit_clr;
    logic data_shift;
    logic drive_tx;
    logic start_bit;

    assign rx_data = data_shreg;

    // Start bit low, then data LSB first, line held high otherwise
    assign tx = drive_tx ? (start_bit ? 1'b0 : tx_data[bit_cnt]) : 1'b1;

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state <= UART_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst || cycle_clr) begin
            cycle_cnt <= '0;
        end else if (cycle_en) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst || sample_clr) begin
            sample_cnt <= '0;
        end else if (sample_en) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst || bit_clr) begin
            bit_cnt <= '0;
        end else if (bit_en) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Refilled with ones so an old start is not seen again
    always_ff @(posedge clk50MHz) begin
        if (rst || sample_fill) begin
            start_samples <= '1;
        end else if (sample_shift) begin
            start_samples <= {start_samples[START_SAMPLES-2:0], rx};
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (data_shift) begin
            data_shreg <= {rx, data_shreg[7:1]}; // LSB arrives first
        end
    end

    always_comb begin
        next_state   = state;
        busy         = 1'b1;
        rx_valid     = 1'b0;
        drive_tx     = 1'b0;
        start_bit    = 1'b0;
        cycle_en     = 1'b0;
        cycle_clr    = 1'b0;
        sample_en    = 1'b0;
        sample_clr   = 1'b0;
        sample_shift = 1'b0;
        sample_fill  = 1'b0;
        bit_en       = 1'b0;
        bit_clr      = 1'b0;
        data_shift   = 1'b0;

        case (state)
            UART_RESET: begin
                cycle_clr   = 1'b1;
                sample_clr  = 1'b1;
                sample_fill = 1'b1;
                bit_clr     = 1'b1;
                next_state  = UART_IDLE;
            end
            UART_IDLE: begin
                busy      = 1'b0;
                sample_en = 1'b1;
                if (sample_cnt == SAMPLE_LAST) begin
                    sample_clr   = 1'b1;
                    sample_shift = 1'b1;
                end
                if (tx_valid) begin // Transmit wins over a pending start
                    next_state = UART_WRITE_START;
                end else if (start_samples == '0) begin
                    next_state = UART_READ_DATA;
                end
            end
            UART_READ_DATA: begin
                cycle_en = 1'b1;
                if (cycle_cnt == BIT_LAST) begin
                    cycle_clr  = 1'b1;
                    data_shift = 1'b1;
                    bit_en     = 1'b1;
                    if (bit_cnt == 3'd7) begin
                        bit_clr    = 1'b1;
                        next_state = UART_FINISH_READ;
                    end
                end
            end
            UART_FINISH_READ: begin
                // Hold off one bit period so the stop bit is not taken as a start
                cycle_en    = 1'b1;
                sample_clr  = 1'b1;
                sample_fill = 1'b1;
                rx_valid    = (cycle_cnt == VALID_CYC);
                if (cycle_cnt == BIT_LAST) begin
                    cycle_clr  = 1'b1;
                    next_state = UART_IDLE;
                end
            end
            UART_WRITE_START: begin
                drive_tx  = 1'b1;
                start_bit = 1'b1;
                cycle_en  = 1'b1;
                if (cycle_cnt == BIT_LAST) begin
                    cycle_clr  = 1'b1;
                    next_state = UART_WRITE_DATA;
                end
            end
            UART_WRITE_DATA: begin
                drive_tx = 1'b1;
                cycle_en = 1'b1;
                if (cycle_cnt == BIT_LAST) begin
                    cycle_clr = 1'b1;
                    bit_en    = 1'b1;
                    if (bit_cnt == 3'd7) begin
                        bit_clr    = 1'b1;
                        next_state = UART_FINISH_WRITE;
                    end
                end
            end
            UART_FINISH_WRITE: begin
                cycle_en    = 1'b1; // Stop level lasts two bit periods
                sample_clr  = 1'b1;
                sample_fill = 1'b1;
                if (cycle_cnt == STOP_LAST) begin
                    cycle_clr  = 1'b1;
                    next_state = UART_IDLE;
                end
            end
            default: begin
                next_state = UART_IDLE;
            end
        endcase
    end

endmodule

//--- logic/line_fifo.sv
`timescale 1ns/1ps

module line_fifo import uart_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic       clk50MHz,
    input  logic       rst,
    input  logic       push,
    input  uart_byte_t push_data,
    input  logic       pop,
    output uart_byte_t head_data,
    output logic       empty,
    output logic       full
);

    localparam int PTR_W = $clog2(DEPTH);

    localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(DEPTH);

    uart_byte_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty     = (count == '0);
    assign full      = (count == COUNT_FULL);
    assign head_data = mem[rd_ptr]; // Head shows without a read cycle

    always_ff @(posedge clk50MHz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/echo_ctrl.sv
`timescale 1ns/1ps

module echo_ctrl import uart_pkg::*; (
    input  logic       clk50MHz,
    input  logic       rst,
    input  uart_byte_t rx_data,
    input  logic       rx_valid,
    input  logic       busy,
    output uart_byte_t tx_data,
    output logic       tx_valid,
    output logic       push,
    output uart_byte_t push_data,
    output logic       pop,
    input  uart_byte_t head_data,
    input  logic       empty,
    input  logic       full
);

    echo_state_t state;
    logic        cr_sent; // Set once the closing CR is on its way

    function automatic uart_byte_t to_upper(input uart_byte_t b);
        if (b >= ASCII_LC_A && b <= ASCII_LC_Z) begin
            return b & ~ASCII_CASE_BIT;
        end
        return b;
    endfunction

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state    <= ECHO_COLLECT;
            cr_sent  <= 1'b0;
            tx_valid <= 1'b0;
            push     <= 1'b0;
            pop      <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            push     <= 1'b0;
            pop      <= 1'b0;
            case (state)
                ECHO_COLLECT: begin
                    if (rx_valid) begin
                        if (rx_data == ASCII_CR) begin
                            state <= ECHO_LAUNCH;
                        end else begin
                            push <= !full; // Full line drops the byte
                        end
                    end
                end
                ECHO_LAUNCH: begin
                    if (!busy) begin
                        if (empty) begin
                            state <= ECHO_SEND_CR;
                        end else begin
                            tx_data  <= head_data;
                            tx_valid <= 1'b1;
                            pop      <= 1'b1;
                            state    <= ECHO_WAIT_BUSY;
                        end
                    end
                end
                ECHO_SEND_CR: begin
                    if (!busy) begin
                        tx_data  <= ASCII_CR;
                        tx_valid <= 1'b1;
                        cr_sent  <= 1'b1;
                        state    <= ECHO_WAIT_BUSY;
                    end
                end
                ECHO_WAIT_BUSY: begin
                    if (busy) begin
                        state <= ECHO_WAIT_IDLE;
                    end
                end
                ECHO_WAIT_IDLE: begin
                    if (!busy) begin
                        cr_sent <= 1'b0;
                        state   <= cr_sent ? ECHO_COLLECT : ECHO_LAUNCH;
                    end
                end
                default: begin
                    state <= ECHO_COLLECT;
                end
            endcase
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rx_valid) begin
            push_data <= to_upper(rx_data);
        end
    end

endmodule

//--- logic/uart_echo.sv
`timescale 1ns/1ps

module uart_echo import uart_pkg::*; #(
    parameter int CLK_HZ     = 50000000,
    parameter int BAUD       = 9600,
    parameter int LINE_DEPTH = 16
) (
    input  logic clk50MHz,
    input  logic rst,
    input  logic rx,
    output logic tx,
    output logic busy
);

    uart_byte_t rx_data;
    logic       rx_valid;
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       push;
    uart_byte_t push_data;
    logic       pop;
    uart_byte_t head_data;
    logic       empty;
    logic       full;

    uart #(
        .CLK_HZ(CLK_HZ),
        .BAUD  (BAUD)
    ) uart_i (
        .clk50MHz(clk50MHz),
        .rst     (rst),
        .rx      (rx),
        .tx      (tx),
        .busy    (busy),
        .rx_data (rx_data),
        .rx_valid(rx_valid),
        .tx_data (tx_data),
        .tx_valid(tx_valid)
    );

    // Holds one line until its CR arrives
    line_fifo #(
        .DEPTH(LINE_DEPTH)
    ) line_fifo_i (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .head_data(head_data),
        .empty    (empty),
        .full     (full)
    );

    echo_ctrl echo_ctrl_i (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .busy     (busy),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .head_data(head_data),
        .empty    (empty),
        .full     (full)
    );

endmodule

//--- testbench/tb_uart_echo.sv
`timescale 1ns/1ps

module tb_uart_echo import uart_pkg::*; ();

    localparam int CLK_HZ      = 50000000;
    localparam int BAUD        = 1562500;
    localparam int LINE_DEPTH  = 8;
    localparam int BIT_CLKS    = CLK_HZ / BAUD;
    localparam int SAMPLE_CLKS = BIT_CLKS / SAMPLES_PER_BIT;
    localparam int FRAME_CLKS  = 12 * BIT_CLKS;
    localparam int NUM_TESTS   = 6;
    localparam int MAX_LEN     = 12;
    localparam int MAX_ECHO    = 16;

    logic clk50MHz;
    logic rst;
    logic rx;
    logic tx;
    logic busy;

    uart_byte_t stim_tab [NUM_TESTS][MAX_LEN];
    uart_byte_t exp_tab  [NUM_TESTS][MAX_LEN];
    int         stim_len [NUM_TESTS];
    int         exp_len  [NUM_TESTS]; // Closing CR included
    string      name_tab [NUM_TESTS];
    int         table_bytes;
    logic       table_ready;
    logic [7:0] lfsr_state;
    logic       line_driven;
    uart_byte_t echo_q [$];
    int         error_count;
    int         fail_tests;

    uart_echo #(
        .CLK_HZ    (CLK_HZ),
        .BAUD      (BAUD),
        .LINE_DEPTH(LINE_DEPTH)
    ) dut_i (
        .clk50MHz(clk50MHz),
        .rst     (rst),
        .rx      (rx),
        .tx      (tx),
        .busy    (busy)
    );

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic uart_byte_t echoed(input uart_byte_t b);
        if (b >= 8'h61 && b <= 8'h7A) begin
            return b - 8'h20;
        end
        return b;
    endfunction

    task automatic take_random_byte(output uart_byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        if (b == ASCII_CR) begin
            b = 8'h20; // A CR would end the line early
        end
    endtask

    task automatic add_fixed(input int idx, input string name, input string stim,
                             input string echo_str);
        name_tab[idx] = name;
        stim_len[idx] = stim.len();
        exp_len[idx]  = echo_str.len() + 1;
        for (int i = 0; i < stim.len(); i++) begin
            stim_tab[idx][i] = stim[i];
        end
        for (int i = 0; i < echo_str.len(); i++) begin
            exp_tab[idx][i] = echo_str[i];
        end
        exp_tab[idx][echo_str.len()] = ASCII_CR;
    endtask

    task automatic add_random(input int idx, input int len);
        uart_byte_t b;
        name_tab[idx] = "random bytes";
        stim_len[idx] = len;
        exp_len[idx]  = ((len < LINE_DEPTH) ? len : LINE_DEPTH) + 1;
        for (int i = 0; i < len; i++) begin
            take_random_byte(b);
            stim_tab[idx][i] = b;
            if (i < LINE_DEPTH) begin
                exp_tab[idx][i] = echoed(b);
            end
        end
        exp_tab[idx][exp_len[idx] - 1] = ASCII_CR;
    endtask

    task automatic load_table();
        add_fixed(0, "mixed case letters", "hElLo wO", "HELLO WO");
        add_fixed(1, "digits, symbols and capitals", "AZ09{`@~", "AZ09{`@~");
        add_fixed(2, "line longer than the buffer", "longer line!", "LONGER L");
        add_fixed(3, "empty line", "", "");
        add_random(4, 7);
        add_random(5, 12);
        table_bytes = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            table_bytes += stim_len[t] + 1;
        end
    endtask

    task automatic check_byte(input int pos, input uart_byte_t exp, input uart_byte_t got);
        if (got !== exp) begin
            $display("** Error at %0t: echoed byte %0d is %h, expected %h", $time, pos, got, exp);
            error_count++;
        end
    endtask

    task automatic check_length(input int exp, input int got);
        if (got !== exp) begin
            $display("** Error at %0t: echoed %0d bytes, expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic got);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %0d, %s: ok", num, name);
        end else begin
            $display("Test %0d, %s: failed", num, name);
            fail_tests++;
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic drive_bit(input logic b);
        rx = b;
        repeat (BIT_CLKS) @(posedge clk50MHz);
        #1;
    endtask

    task automatic send_line(input int idx);
        uart_byte_t b;
        for (int n = 0; n <= stim_len[idx]; n++) begin
            if (n == stim_len[idx]) begin
                b = ASCII_CR;
            end else begin
                b = stim_tab[idx][n];
            end
            drive_bit(1'b0);
            for (int i = 0; i < 8; i++) begin
                drive_bit(b[i]);
            end
            if (n == stim_len[idx]) begin
                line_driven = 1'b1; // Echo can start during this stop bit
            end
            drive_bit(1'b1);
        end
    endtask

    task automatic wait_start(output logic found);
        found = 1'b0;
        for (int c = 0; c < 4 * FRAME_CLKS && !found; c++) begin
            @(negedge clk50MHz);
            found = (tx == 1'b0);
        end
    endtask

    task automatic capture_echo();
        uart_byte_t b;
        logic       found;
        logic       done;
        echo_q.delete();
        b    = '0;
        done = 1'b0;
        while (!done && echo_q.size() < MAX_ECHO) begin
            wait_start(found);
            if (!found) begin
                $display("No start bit on tx within 4 frame times after %0d echoed bytes",
                         echo_q.size());
                error_count++;
                return;
            end
            repeat (BIT_CLKS / 2) @(negedge clk50MHz); // Middle of the start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk50MHz);
                b[i] = tx;
            end
            repeat (BIT_CLKS) @(negedge clk50MHz);
            check_level("tx stop level", 1'b1, tx);
            echo_q.push_back(b);
            done = (b == ASCII_CR);
        end
    endtask

    task automatic wait_idle();
        int c;
        c = 0;
        while (busy !== 1'b0 && c < 4 * FRAME_CLKS) begin
            @(negedge clk50MHz);
            c++;
        end
        if (busy !== 1'b0) begin
            $display("UART still busy 4 frame times after the echo ended");
            error_count++;
        end
        repeat (2 * BIT_CLKS) @(posedge clk50MHz);
        #1;
    endtask

    task automatic check_idle();
        int errors_before;
        errors_before = error_count;
        repeat (2) @(posedge clk50MHz); // Busy is high for one clock after reset
        for (int s = 0; s < 4 * SAMPLES_PER_BIT; s++) begin
            repeat (SAMPLE_CLKS) @(negedge clk50MHz);
            check_level("tx", 1'b1, tx);
            check_level("busy", 1'b0, busy);
        end
        @(posedge clk50MHz);
        #1;
        report_test(1, "idle after reset", errors_before);
    endtask

    task automatic run_line(input int idx);
        int errors_before;
        int n;
        errors_before = error_count;
        line_driven   = 1'b0;
        fork
            send_line(idx);
            begin
                wait (line_driven);
                capture_echo();
            end
        join
        check_length(exp_len[idx], echo_q.size());
        n = (echo_q.size() < exp_len[idx]) ? echo_q.size() : exp_len[idx];
        for (int i = 0; i < n; i++) begin
            check_byte(i, exp_tab[idx][i], echo_q[i]);
        end
        wait_idle();
        report_test(idx + 2, name_tab[idx], errors_before);
    endtask

    initial begin
        rst         = 1'b1;
        rx          = 1'b1;
        error_count = 0;
        fail_tests  = 0;
        line_driven = 1'b0;
        table_ready = 1'b0;
        lfsr_state  = 8'd28;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk50MHz);
        #1;
        rst = 1'b0;
        check_idle();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_line(t);
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 NUM_TESTS + 1, fail_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = table_bytes * 2 * FRAME_CLKS * 2 + 8 * FRAME_CLKS; // Room for reset and idle check
        repeat (limit) @(posedge clk50MHz);
        $display("Watchdog expired after %0d clocks, the run did not finish", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- uart_echo.f
common/uart_pkg.sv
uart/uart.sv
logic/line_fifo.sv
logic/echo_ctrl.sv
logic/uart_echo.sv
testbench/tb_uart_echo.sv

//--- Makefile
TOP := tb_uart_echo

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module uart_echo -f uart_echo.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f uart_echo.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir
